// File: design/spi_flash_pkg.sv
package spi_flash_pkg;

  // one byte on the wire
  typedef logic [7:0] byte_t;

  // slot tag: 0 for cmd/addr, 1..4 for byte position in the word
  typedef logic [2:0] tag_t;

  // 3-byte flash address
  typedef logic [23:0] flash_addr_t;

  // commands, single-bit spi only
  localparam byte_t CMD_EXIT_CONT = 8'hFF;  // leave continuous read
  localparam byte_t CMD_WAKE      = 8'hAB;  // release power-down
  localparam byte_t CMD_READ      = 8'h03;  // plain read

  // config word layout
  localparam int CFG_EN_BIT  = 31;  // controller owns the pins
  localparam int CFG_OE_LSB  = 8;   // 4 output enables
  localparam int CFG_CSB_BIT = 5;
  localparam int CFG_CLK_BIT = 4;
  localparam int CFG_DO_LSB  = 0;   // 4 data bits, di on read-back

endpackage

// File: design/flash_cfg_reg.sv
module flash_cfg_reg import spi_flash_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic [3:0]  cfg_wstrb,
  input  logic [31:0] cfg_wdata,
  input  logic        ctl_csb,
  input  logic        ctl_sclk,
  input  logic        ctl_io0,
  input  logic [3:0]  flash_io_di,
  output logic [31:0] cfg_rdata,
  output logic        soft_reset,
  output logic        flash_csb,
  output logic        flash_clk,
  output logic [3:0]  flash_io_oe,
  output logic [3:0]  flash_io_do
);

  logic       cfg_en;
  logic [3:0] cfg_oe;
  logic       cfg_csb;
  logic       cfg_clk;
  logic [3:0] cfg_do;
  logic       ctl_drive;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cfg_en     <= 1'b1;
      cfg_oe     <= 4'b0000;
      cfg_csb    <= 1'b1;
      cfg_clk    <= 1'b0;
      cfg_do     <= 4'b0000;
      soft_reset <= 1'b1;
      ctl_drive  <= 1'b0;
    end else begin
      soft_reset <= !cfg_en || (|cfg_wstrb);  // restart wake-up after any write
      ctl_drive  <= 1'b1;                     // io0 driven once out of reset
      if (cfg_wstrb[0]) begin
        cfg_csb <= cfg_wdata[CFG_CSB_BIT];
        cfg_clk <= cfg_wdata[CFG_CLK_BIT];
        cfg_do  <= cfg_wdata[CFG_DO_LSB +: 4];
      end
      if (cfg_wstrb[1]) cfg_oe <= cfg_wdata[CFG_OE_LSB +: 4];
      if (cfg_wstrb[3]) cfg_en <= cfg_wdata[CFG_EN_BIT];
    end
  end

  // single-bit spi: io0 out, io1..io3 in
  assign flash_csb   = cfg_en ? ctl_csb : cfg_csb;
  assign flash_clk   = cfg_en ? ctl_sclk : cfg_clk;
  assign flash_io_oe = cfg_en ? {3'b000, ctl_drive} : cfg_oe;
  assign flash_io_do = cfg_en ? {3'b000, ctl_io0} : cfg_do;

  always_comb begin
    cfg_rdata                   = '0;  // mode bits 22:16 read as zero
    cfg_rdata[CFG_EN_BIT]       = cfg_en;
    cfg_rdata[CFG_OE_LSB +: 4]  = flash_io_oe;
    cfg_rdata[CFG_CSB_BIT]      = flash_csb;
    cfg_rdata[CFG_CLK_BIT]      = flash_clk;
    cfg_rdata[CFG_DO_LSB +: 4]  = flash_io_di;  // live input pins
  end

endmodule

// File: design/flash_read_seq.sv
module flash_read_seq import spi_flash_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic        soft_reset,
  input  logic        valid,
  input  flash_addr_t addr,
  input  logic        byte_accept,
  input  logic        byte_done,
  input  logic        jump,
  input  logic        hold,
  output logic        byte_start,
  output byte_t       byte_out,
  output tag_t        byte_tag,
  output logic        shift_clear
);

  localparam logic [3:0] ST_EXIT     = 4'd0;
  localparam logic [3:0] ST_EXIT_END = 4'd1;
  localparam logic [3:0] ST_WAKE     = 4'd2;
  localparam logic [3:0] ST_WAKE_END = 4'd3;
  localparam logic [3:0] ST_CMD      = 4'd4;
  localparam logic [3:0] ST_ADDR_HI  = 4'd5;
  localparam logic [3:0] ST_ADDR_MID = 4'd6;
  localparam logic [3:0] ST_ADDR_LO  = 4'd7;
  localparam logic [3:0] ST_DATA     = 4'd8;

  logic [3:0] state;
  tag_t       data_tag;
  logic       slot_req;
  logic       wake_end;

  always_comb begin
    slot_req = 1'b0;
    byte_out = 8'h00;  // io0 idles low during data slots
    byte_tag = 3'd0;
    case (state)
      ST_EXIT: begin
        slot_req = 1'b1;
        byte_out = CMD_EXIT_CONT;
      end
      ST_WAKE: begin
        slot_req = 1'b1;
        byte_out = CMD_WAKE;
      end
      ST_CMD: begin
        slot_req = 1'b1;
        byte_out = CMD_READ;
      end
      ST_ADDR_HI: begin
        slot_req = valid;  // buffer is empty here, so no ready to check
        byte_out = addr[23:16];
      end
      ST_ADDR_MID: begin
        slot_req = 1'b1;
        byte_out = addr[15:8];
      end
      ST_ADDR_LO: begin
        slot_req = 1'b1;
        byte_out = addr[7:0];
      end
      ST_DATA: begin
        slot_req = !(data_tag == 3'd4 && hold);  // park before last byte
        byte_tag = data_tag;
      end
      default: begin
        slot_req = 1'b0;
      end
    endcase
  end

  // each wake-up byte is a frame of its own
  assign wake_end    = (state == ST_EXIT_END || state == ST_WAKE_END) && byte_done;
  assign shift_clear = soft_reset || jump || wake_end;
  assign byte_start  = slot_req && !shift_clear;

  always_ff @(posedge clk) begin
    if (!resetn || soft_reset) begin
      state    <= ST_EXIT;
      data_tag <= 3'd1;
    end else if (jump) begin
      state    <= ST_CMD;  // new frame at the requested address
      data_tag <= 3'd1;
    end else begin
      case (state)
        ST_EXIT: begin
          if (byte_accept) state <= ST_EXIT_END;
        end
        ST_EXIT_END: begin
          if (byte_done) state <= ST_WAKE;
        end
        ST_WAKE: begin
          if (byte_accept) state <= ST_WAKE_END;
        end
        ST_WAKE_END: begin
          if (byte_done) state <= ST_CMD;
        end
        ST_CMD: begin
          if (byte_accept) state <= ST_ADDR_HI;
        end
        ST_ADDR_HI: begin
          if (byte_accept) state <= ST_ADDR_MID;
        end
        ST_ADDR_MID: begin
          if (byte_accept) state <= ST_ADDR_LO;
        end
        ST_ADDR_LO: begin
          if (byte_accept) begin
            state    <= ST_DATA;
            data_tag <= 3'd1;
          end
        end
        ST_DATA: begin
          if (byte_accept) data_tag <= (data_tag == 3'd4) ? 3'd1 : data_tag + 3'd1;
        end
        default: begin
          state <= ST_EXIT;
        end
      endcase
    end
  end

endmodule

// File: design/spi_byte_shifter.sv
module spi_byte_shifter import spi_flash_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  logic       shift_clear,
  input  logic       byte_start,
  input  byte_t      byte_out,
  input  tag_t       byte_tag,
  input  logic [3:0] flash_io_di,
  output logic       byte_accept,
  output logic       byte_done,
  output byte_t      byte_in,
  output tag_t       done_tag,
  output logic       ctl_csb,
  output logic       ctl_sclk,
  output logic       ctl_io0
);

  logic [3:0] bit_cnt;  // falling edges left in the slot
  byte_t      obuf;
  byte_t      ibuf;
  tag_t       tag_q;

  assign byte_accept = byte_start && (bit_cnt == 4'd0);
  assign ctl_io0     = obuf[7];  // msb first
  assign byte_in     = ibuf;
  assign done_tag    = tag_q;

  always_ff @(posedge clk) begin
    if (!resetn || shift_clear) begin
      ctl_csb   <= 1'b1;
      ctl_sclk  <= 1'b0;
      bit_cnt   <= 4'd0;
      byte_done <= 1'b0;
    end else begin
      byte_done <= 1'b0;
      if (byte_accept) begin
        ctl_csb  <= 1'b0;  // stays low between slots
        ctl_sclk <= 1'b0;
        bit_cnt  <= 4'd8;
      end else if (bit_cnt != 4'd0) begin
        ctl_sclk <= !ctl_sclk;
        if (ctl_sclk) bit_cnt <= bit_cnt - 4'd1;
        byte_done <= ctl_sclk && (bit_cnt == 4'd1);  // after the last rising edge
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_accept) begin
      obuf  <= byte_out;
      tag_q <= byte_tag;
    end else if (bit_cnt != 4'd0) begin
      if (ctl_sclk) begin
        obuf <= {obuf[6:0], 1'b0};  // io0 moves while sclk goes low
      end else begin
        ibuf <= {ibuf[6:0], flash_io_di[1]};  // sample ahead of the rising edge
      end
    end
  end

endmodule

// File: design/word_assembler.sv
module word_assembler import spi_flash_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic        soft_reset,
  input  logic        valid,
  input  flash_addr_t addr,
  input  logic        byte_done,
  input  byte_t       byte_in,
  input  tag_t        done_tag,
  output logic        ready,
  output logic [31:0] rdata,
  output logic        jump,
  output logic        hold
);

  logic [23:0] low_bytes;  // bytes 1..3 of the word in flight
  flash_addr_t buf_addr;
  flash_addr_t next_addr;
  logic        word_valid;
  logic        streaming;  // next word continues the open frame
  logic        wait_q;
  logic        word_done;

  assign next_addr = buf_addr + 24'd4;
  assign word_done = byte_done && (done_tag == 3'd4);
  assign ready     = valid && word_valid && (addr == buf_addr);
  assign jump      = valid && !ready && word_valid && (addr != next_addr);
  assign hold      = wait_q;

  always_ff @(posedge clk) begin
    if (!resetn || soft_reset) begin
      word_valid <= 1'b0;
      streaming  <= 1'b0;
      wait_q     <= 1'b0;
    end else begin
      if (word_done) begin
        word_valid <= 1'b1;
        streaming  <= 1'b1;
        wait_q     <= streaming;  // prefetched word not yet asked for
      end
      if (valid) wait_q <= 1'b0;
      if (jump) begin
        word_valid <= 1'b0;
        streaming  <= 1'b0;
        wait_q     <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (byte_done) begin
      case (done_tag)
        3'd1: low_bytes[7:0]   <= byte_in;
        3'd2: low_bytes[15:8]  <= byte_in;
        3'd3: low_bytes[23:16] <= byte_in;
        3'd4: begin
          rdata    <= {byte_in, low_bytes};  // little endian
          buf_addr <= streaming ? next_addr : addr;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: design/spi_flash_rom.sv
module spi_flash_rom import spi_flash_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic        valid,
  output logic        ready,
  input  flash_addr_t addr,
  output logic [31:0] rdata,
  input  logic [3:0]  cfg_wstrb,
  input  logic [31:0] cfg_wdata,
  output logic [31:0] cfg_rdata,
  output logic        flash_csb,
  output logic        flash_clk,
  output logic [3:0]  flash_io_oe,
  output logic [3:0]  flash_io_do,
  input  logic [3:0]  flash_io_di
);

  logic  soft_reset;
  logic  ctl_csb;
  logic  ctl_sclk;
  logic  ctl_io0;
  logic  byte_start;
  logic  byte_accept;
  byte_t byte_out;
  tag_t  byte_tag;
  logic  shift_clear;
  logic  byte_done;
  byte_t byte_in;
  tag_t  done_tag;
  logic  jump;
  logic  hold;

  flash_cfg_reg u_flash_cfg_reg (
    .clk, .resetn, .cfg_wstrb, .cfg_wdata, .ctl_csb, .ctl_sclk, .ctl_io0,
    .flash_io_di, .cfg_rdata, .soft_reset, .flash_csb, .flash_clk,
    .flash_io_oe, .flash_io_do
  );

  flash_read_seq u_flash_read_seq (
    .clk, .resetn, .soft_reset, .valid, .addr, .byte_accept, .byte_done,
    .jump, .hold, .byte_start, .byte_out, .byte_tag, .shift_clear
  );

  spi_byte_shifter u_spi_byte_shifter (
    .clk, .resetn, .shift_clear, .byte_start, .byte_out, .byte_tag,
    .flash_io_di, .byte_accept, .byte_done, .byte_in, .done_tag,
    .ctl_csb, .ctl_sclk, .ctl_io0
  );

  word_assembler u_word_assembler (
    .clk, .resetn, .soft_reset, .valid, .addr, .byte_done, .byte_in,
    .done_tag, .ready, .rdata, .jump, .hold
  );

endmodule

// File: verif/spi_flash_props.sv
module spi_flash_props import spi_flash_pkg::*; (
  input logic        clk,
  input logic        resetn,
  input logic        valid,
  input logic        ready,
  input logic        flash_csb,
  input logic        flash_clk,
  input logic [3:0]  flash_io_oe,
  input logic [31:0] cfg_rdata
);

  // enable bit taken from the live read-back
  // a buffered word only exists inside an open read frame
  assert property (@(posedge clk) disable iff (!resetn)
    (cfg_rdata[CFG_EN_BIT] && ready) |-> (valid && !flash_csb))
    else $error("ready raised without valid or outside a read frame");

  assert property (@(posedge clk) disable iff (!resetn)
    (cfg_rdata[CFG_EN_BIT] && flash_csb) |-> !flash_clk)
    else $error("flash_clk high while chip select is idle");

  // io0 is driven from the second cycle after reset on
  assert property (@(posedge clk) disable iff (!resetn)
    (cfg_rdata[CFG_EN_BIT] && $past(resetn)) |-> (flash_io_oe == 4'b0001))
    else $error("output enables differ from single-bit spi");

endmodule

bind spi_flash_rom spi_flash_props u_spi_flash_props (.*);

// File: verif/tb_spi_flash_rom.sv
module tb_spi_flash_rom import spi_flash_pkg::*;;

  logic        clk;
  logic        resetn;
  logic        valid;
  logic        ready;
  flash_addr_t addr;
  logic [31:0] rdata;
  logic [3:0]  cfg_wstrb;
  logic [31:0] cfg_wdata;
  logic [31:0] cfg_rdata;
  logic        flash_csb;
  logic        flash_clk;
  logic [3:0]  flash_io_oe;
  logic [3:0]  flash_io_do;
  logic [3:0]  flash_io_di;
  logic [2:0]  di_rand;   // io0, io2, io3 seen by the dut
  logic        model_io1;
  logic [31:0] lfsr;

  // flash model state
  int          frame_cnt;
  int          mbits;
  byte_t       sh;
  byte_t       hdr [4];
  flash_addr_t rd_addr;
  byte_t       first_bytes [$];

  assign flash_io_di = {di_rand[2:1], model_io1, di_rand[0]};

  spi_flash_rom u_spi_flash_rom (
    .clk, .resetn, .valid, .ready, .addr, .rdata, .cfg_wstrb, .cfg_wdata,
    .cfg_rdata, .flash_csb, .flash_clk, .flash_io_oe, .flash_io_do, .flash_io_di
  );

  always #5 clk = !clk;

  function automatic byte_t mem_byte(input flash_addr_t a);
    flash_addr_t v;
    v = a ^ (a >> 8) ^ 24'h00005A;
    return v[7:0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  always @(negedge flash_csb) begin
    frame_cnt = frame_cnt + 1;
    mbits     = 0;
  end

  always @(posedge flash_clk) begin
    if (!flash_csb) begin
      sh    = {sh[6:0], flash_io_do[0]};
      mbits = mbits + 1;
      if ((mbits % 8) == 0 && mbits <= 32) begin
        hdr[mbits / 8 - 1] = sh;
        if (mbits == 8) first_bytes.push_back(sh);
      end
      if (mbits == 32) rd_addr = {hdr[1], hdr[2], hdr[3]};
    end
  end

  // data goes out on io1 after each falling edge
  always @(negedge flash_clk) begin
    int          off;
    byte_t       b;
    flash_addr_t a;
    if (!flash_csb && mbits >= 32) begin
      off = mbits - 32;
      a   = rd_addr + flash_addr_t'(off / 8);
      b   = mem_byte(a);
      model_io1 <= b[3'd7 - 3'(off % 8)];
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic wait_frames(input int n);
    int t;
    t = 0;
    while (first_bytes.size() < n) begin
      @(negedge clk);
      t++;
      if (t > 2000) stop_on_timeout("wake-up frames");
    end
  endtask

  task automatic read_word(input flash_addr_t a);
    int          t;
    logic [31:0] exp;
    exp = {mem_byte(a + 24'd3), mem_byte(a + 24'd2), mem_byte(a + 24'd1), mem_byte(a)};
    @(posedge clk);
    valid <= 1'b1;
    addr  <= a;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (t > 3000) stop_on_timeout("ready");
    end while (!ready);
    check_val("rdata", rdata, exp);
    @(posedge clk);
    valid <= 1'b0;
  endtask

  task automatic write_cfg(input logic [3:0] strb, input logic [31:0] data);
    @(posedge clk);
    cfg_wstrb <= strb;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_wstrb <= 4'b0000;
  endtask

  initial begin
    flash_addr_t a;
    flash_addr_t b;
    logic [31:0] r;
    int          f0;
    int          n;
    clk         = 1'b0;
    resetn      = 1'b0;
    valid       = 1'b0;
    addr        = '0;
    cfg_wstrb   = 4'b0000;
    cfg_wdata   = '0;
    di_rand     = 3'b000;
    model_io1   = 1'b0;
    lfsr        = 32'h00335f06;
    frame_cnt   = 0;
    mbits       = 0;
    sh          = 8'h00;
    rd_addr     = '0;
    repeat (3) @(posedge clk);
    resetn <= 1'b1;

    // wake-up frames
    wait_frames(2);
    check_val("frame 1 byte", {24'h0, first_bytes[0]}, 32'h0000_00ff);
    check_val("frame 2 byte", {24'h0, first_bytes[1]}, 32'h0000_00ab);

    // nothing is buffered when the first read comes
    a = flash_addr_t'(rand_bits(22) << 2);
    @(posedge clk);
    valid <= 1'b1;
    addr  <= a;
    @(negedge clk);
    check_val("ready", {31'h0, ready}, 32'h0);
    read_word(a);

    // random reads
    for (int i = 1; i < 8; i++) begin
      a = flash_addr_t'(rand_bits(22) << 2);
      read_word(a);
    end

    // streamed reads stay in one frame
    a = flash_addr_t'(rand_bits(22) << 2);
    read_word(a);
    f0 = frame_cnt;
    for (int i = 1; i < 4; i++) begin
      read_word(a + flash_addr_t'(4 * i));
    end
    check_val("frame count", 32'(frame_cnt), 32'(f0));

    // jump opens a new frame
    b  = a + 24'h010000;
    f0 = frame_cnt;
    read_word(b);
    check_val("frame count", 32'(frame_cnt), 32'(f0 + 1));
    check_val("cmd byte", {24'h0, hdr[0]}, 32'h0000_0003);
    check_val("addr bytes", {8'h0, hdr[1], hdr[2], hdr[3]}, {8'h0, b});

    // bit-bang pins
    for (int i = 0; i < 4; i++) begin
      r = rand_bits(32);
      r[31] = 1'b0;
      @(posedge clk);
      di_rand <= 3'(rand_bits(3));
      write_cfg(4'b1011, r);
      @(negedge clk);
      check_val("flash_csb", {31'h0, flash_csb}, {31'h0, r[5]});
      check_val("flash_clk", {31'h0, flash_clk}, {31'h0, r[4]});
      check_val("flash_io_oe", {28'h0, flash_io_oe}, {28'h0, r[11:8]});
      check_val("flash_io_do", {28'h0, flash_io_do}, {28'h0, r[3:0]});
      check_val("cfg_rdata", cfg_rdata, {20'h0, r[11:8], 2'b00, r[5], r[4], flash_io_di});
    end

    // back to the controller
    n = first_bytes.size();
    @(posedge clk);
    di_rand <= 3'b000;
    write_cfg(4'b1000, 32'h8000_0000);
    wait_frames(n + 2);
    check_val("frame byte", {24'h0, first_bytes[n]}, 32'h0000_00ff);
    check_val("frame byte", {24'h0, first_bytes[n + 1]}, 32'h0000_00ab);
    a = flash_addr_t'(rand_bits(22) << 2);
    read_word(a);

    $display("all tests passed");
    $finish;
  end

endmodule

// File: spi_flash_rom.f
design/spi_flash_pkg.sv
design/flash_cfg_reg.sv
design/flash_read_seq.sv
design/spi_byte_shifter.sv
design/word_assembler.sv
design/spi_flash_rom.sv
verif/spi_flash_props.sv
verif/tb_spi_flash_rom.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f spi_flash_rom.f \
  --top-module tb_spi_flash_rom -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log

grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log && exit 0 || exit 1
